// File: all.f
logic/dcache_pkg.sv
logic/dcache_array.sv
logic/linefill_buffer.sv
logic/line_write_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/tb_clock.sv
tests/mem_model.sv
tests/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/dcache_array.sv
      - logic/linefill_buffer.sv
      - logic/line_write_buffer.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/mem_model.sv
      - tests/dcache_tb.sv

// File: tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

   localparam int TIMEOUT_CYCLES = 4000;

   logic              Clk;
   logic              rst_n;
   logic              bp_en;
   logic              cpu_req;
   logic              cpu_we;
   dcache_pkg::addr_t cpu_addr;
   dcache_pkg::word_t cpu_wdata;
   wire               cpu_ready;
   dcache_pkg::word_t cpu_rdata;
   wire               ar_valid;
   dcache_pkg::addr_t ar_addr;
   wire               ar_ready;
   wire               r_valid;
   dcache_pkg::word_t r_data;
   wire               r_last;
   wire               aw_valid;
   dcache_pkg::addr_t aw_addr;
   wire               aw_ready;
   wire               w_valid;
   dcache_pkg::word_t w_data;
   wire               w_last;
   wire               w_ready;
   wire               b_valid;

   // Reference memory and a tag model of the cache
   dcache_pkg::word_t ref_mem [1024];
   dcache_pkg::tag_t  c_tag   [8];
   logic              c_valid [8];
   logic              c_dirty [8];
   logic [31:0]       seed;
   int                cycle_count;

   tb_clock u_clk (.clk_o(Clk));

   mem_model u_mem (
      .Clk(Clk), .rst_n_i(rst_n), .bp_en_i(bp_en),
      .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_ready_o(ar_ready),
      .r_valid_o(r_valid), .r_data_o(r_data), .r_last_o(r_last),
      .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_ready_o(aw_ready),
      .w_valid_i(w_valid), .w_data_i(w_data), .w_last_i(w_last),
      .w_ready_o(w_ready), .b_valid_o(b_valid)
   );

   dcache_top DUT (
      .Clk(Clk), .rst_n_i(rst_n),
      .cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr),
      .cpu_wdata_i(cpu_wdata), .cpu_ready_o(cpu_ready), .cpu_rdata_o(cpu_rdata),
      .mem_ar_valid_o(ar_valid), .mem_ar_addr_o(ar_addr), .mem_ar_ready_i(ar_ready),
      .mem_r_valid_i(r_valid), .mem_r_data_i(r_data), .mem_r_last_i(r_last),
      .mem_aw_valid_o(aw_valid), .mem_aw_addr_o(aw_addr), .mem_aw_ready_i(aw_ready),
      .mem_w_valid_o(w_valid), .mem_w_data_o(w_data), .mem_w_last_o(w_last),
      .mem_w_ready_i(w_ready), .mem_b_valid_i(b_valid)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   always @(posedge Clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // One CPU transaction that also updates the reference and tag model
   task automatic cpu_access(input logic we, input dcache_pkg::addr_t addr,
                             input dcache_pkg::word_t wdata,
                             output dcache_pkg::word_t rdata, output int cycles);
      logic [2:0] idx;
      @(negedge Clk);
      cpu_req   = 1'b1;
      cpu_we    = we;
      cpu_addr  = addr;
      cpu_wdata = wdata;
      cycles    = 0;
      do begin
         @(negedge Clk);
         cycles++;
      end while (!cpu_ready);
      rdata   = cpu_rdata;
      cpu_req = 1'b0;
      idx = addr[7:5];
      if (c_valid[idx] && c_tag[idx] == addr[31:8]) begin
         c_dirty[idx] = c_dirty[idx] | we;
      end else begin
         c_valid[idx] = 1'b1;
         c_tag[idx]   = addr[31:8];
         c_dirty[idx] = we;
      end
      if (we) begin
         ref_mem[addr[11:2]] = wdata;
      end
   endtask

   // Wait until both bursts have drained and the FSM is back in IDLE
   task automatic wait_quiet();
      while (u_mem.rd_active || u_mem.aw_seen || u_mem.w_cnt != 0 || u_mem.b_pend
             || b_valid || aw_valid || w_valid || ar_valid) begin
         @(negedge Clk);
      end
      repeat (4) @(negedge Clk);
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic test_reset_idle();
      repeat (5) begin
         @(negedge Clk);
         check_value("cpu_ready_o", cpu_ready, 0);
         check_value("mem_ar_valid_o", ar_valid, 0);
         check_value("mem_aw_valid_o", aw_valid, 0);
         check_value("mem_w_valid_o", w_valid, 0);
      end
   endtask

   task automatic test_read_miss_hit();
      dcache_pkg::word_t rd;
      int                cyc;
      int                ars;
      cpu_access(1'b0, 32'h104, '0, rd, cyc);
      check_value("mem_ar_addr_o", u_mem.last_ar_addr, 32'h104);
      check_value("cpu_rdata_o", rd, ref_mem[32'h104 >> 2]);
      wait_quiet();
      ars = u_mem.ar_count;
      cpu_access(1'b0, 32'h10C, '0, rd, cyc);
      check_value("hit latency", cyc, 2);
      check_value("read address count", u_mem.ar_count, ars);
      check_value("cpu_rdata_o", rd, ref_mem[32'h10C >> 2]);
   endtask

   task automatic test_write_hit();
      dcache_pkg::word_t rd;
      int                cyc;
      int                bursts;
      bursts = u_mem.burst_count;
      cpu_access(1'b1, 32'h108, 32'hA5A5_0001, rd, cyc);
      check_value("write hit latency", cyc, 2);
      cpu_access(1'b0, 32'h108, '0, rd, cyc);
      check_value("cpu_rdata_o", rd, 32'hA5A5_0001);
      // Any stray write-back has to complete before this returns
      wait_quiet();
      check_value("write burst count", u_mem.burst_count, bursts);
   endtask

   task automatic test_dirty_evict();
      dcache_pkg::word_t rd;
      int                cyc;
      int                bursts;
      bursts = u_mem.burst_count;
      cpu_access(1'b0, 32'h904, '0, rd, cyc);
      check_value("cpu_rdata_o", rd, ref_mem[32'h904 >> 2]);
      wait_quiet();
      check_value("write burst count", u_mem.burst_count, bursts + 1);
      check_value("mem_aw_addr_o", u_mem.last_aw_addr, 32'h100);
      check_value("write protocol errors", u_mem.proto_errs, 0);
      for (int k = 0; k < 8; k++) begin
         check_value("mem_w_data_o", u_mem.last_line[k], ref_mem[64 + k]);
      end
   endtask

   task automatic test_write_allocate();
      dcache_pkg::word_t rd;
      int                cyc;
      cpu_access(1'b1, 32'h2A8, 32'h5A5A_1234, rd, cyc);
      cpu_access(1'b0, 32'h2A8, '0, rd, cyc);
      check_value("cpu_rdata_o", rd, 32'h5A5A_1234);
      for (int k = 0; k < 8; k++) begin
         cpu_access(1'b0, 32'h2A0 + 4 * k, '0, rd, cyc);
         check_value("cpu_rdata_o", rd, ref_mem[(32'h2A0 >> 2) + k]);
      end
   endtask

   task automatic test_random_backpressure();
      dcache_pkg::word_t rd;
      dcache_pkg::addr_t addr;
      dcache_pkg::word_t wd;
      logic              we;
      int                cyc;
      int                line;
      // Memory model samples the enable on the falling edge
      @(posedge Clk);
      bp_en = 1'b1;
      for (int n = 0; n < 20; n++) begin
         seed = lcg_step(seed);
         // 24 lines over three tags keep the conflict rate high
         addr = (seed[23:16] % 8'd192) * 4;
         we   = seed[5];
         seed = lcg_step(seed);
         wd   = seed;
         cpu_access(we, addr, wd, rd, cyc);
         if (!we) begin
            check_value("cpu_rdata_o", rd, ref_mem[addr[11:2]]);
         end
      end
      wait_quiet();
      check_value("write protocol errors", u_mem.proto_errs, 0);
      for (line = 0; line < 128; line++) begin
         if (u_mem.wb_mark[line] && !(c_valid[line % 8] && c_dirty[line % 8]
                                      && c_tag[line % 8] == line / 8)) begin
            for (int k = 0; k < 8; k++) begin
               check_value("memory word", u_mem.mem[line * 8 + k], ref_mem[line * 8 + k]);
            end
         end
      end
      bp_en = 1'b0;
   endtask

   initial begin
      rst_n       = 1'b0;
      bp_en       = 1'b0;
      cpu_req     = 1'b0;
      cpu_we      = 1'b0;
      cpu_addr    = '0;
      cpu_wdata   = '0;
      cycle_count = 0;
      seed        = 32'd21;
      for (int i = 0; i < 1024; i++) begin
         seed       = lcg_step(seed);
         ref_mem[i] = seed;
         u_mem.mem[i] = seed;
      end
      for (int i = 0; i < 8; i++) begin
         c_valid[i] = 1'b0;
         c_dirty[i] = 1'b0;
         c_tag[i]   = '0;
      end
      repeat (8) @(negedge Clk);
      rst_n = 1'b1;

      test_reset_idle();
      test_read_miss_hit();
      test_write_hit();
      test_dirty_evict();
      test_write_allocate();
      test_random_backpressure();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
   input  wire                      Clk,
   input  wire                      rst_n_i,
   input  wire                      bp_en_i,
   input  wire                      ar_valid_i,
   input  wire  dcache_pkg::addr_t  ar_addr_i,
   output logic                     ar_ready_o,
   output logic                     r_valid_o,
   output dcache_pkg::word_t        r_data_o,
   output logic                     r_last_o,
   input  wire                      aw_valid_i,
   input  wire  dcache_pkg::addr_t  aw_addr_i,
   output logic                     aw_ready_o,
   input  wire                      w_valid_i,
   input  wire  dcache_pkg::word_t  w_data_i,
   input  wire                      w_last_i,
   output logic                     w_ready_o,
   output logic                     b_valid_o
);

   dcache_pkg::word_t mem       [1024];
   dcache_pkg::word_t wbuf      [8];
   dcache_pkg::word_t last_line [8];
   logic              wb_mark   [128];
   logic [31:0]       rand_q;
   logic              rd_active;
   dcache_pkg::addr_t rd_addr;
   dcache_pkg::addr_t last_ar_addr;
   dcache_pkg::addr_t last_aw_addr;
   logic              aw_seen;
   logic              b_pend;
   int                rd_cnt;
   int                w_cnt;
   int                ar_count;
   int                burst_count;
   int                proto_errs;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   initial begin
      ar_ready_o  = 1'b1;
      r_valid_o   = 1'b0;
      r_data_o    = '0;
      r_last_o    = 1'b0;
      aw_ready_o  = 1'b1;
      w_ready_o   = 1'b1;
      b_valid_o   = 1'b0;
      rand_q      = 32'd21;
      rd_active   = 1'b0;
      aw_seen     = 1'b0;
      b_pend      = 1'b0;
      rd_cnt      = 0;
      w_cnt       = 0;
      ar_count    = 0;
      burst_count = 0;
      proto_errs  = 0;
      for (int i = 0; i < 128; i++) begin
         wb_mark[i] = 1'b0;
      end
   end

   ////////////////////
   // Read channels
   ////////////////////

   // Decisions made on the falling edge take effect at the next rising edge
   always @(negedge Clk) begin
      r_valid_o = 1'b0;
      r_last_o  = 1'b0;
      if (rd_active) begin
         r_valid_o = 1'b1;
         r_data_o  = mem[{rd_addr[11:5], 3'(rd_addr[4:2] + rd_cnt)}];
         r_last_o  = (rd_cnt == 7);
         rd_cnt++;
         if (rd_cnt == 8) begin
            rd_active = 1'b0;
         end
      end else if (rst_n_i && ar_valid_i && ar_ready_o) begin
         rd_active    = 1'b1;
         rd_cnt       = 0;
         rd_addr      = ar_addr_i;
         last_ar_addr = ar_addr_i;
         ar_count++;
      end
   end

   ////////////////////
   // Write channels
   ////////////////////

   always @(negedge Clk) begin
      b_valid_o = b_pend;
      b_pend    = 1'b0;
      if (bp_en_i) begin
         rand_q     = lcg_step(rand_q);
         aw_ready_o = rand_q[16];
         w_ready_o  = rand_q[20];
      end else begin
         aw_ready_o = 1'b1;
         w_ready_o  = 1'b1;
      end
      if (rst_n_i && aw_valid_i && aw_ready_o) begin
         aw_seen      = 1'b1;
         last_aw_addr = aw_addr_i;
      end
      if (rst_n_i && w_valid_i && w_ready_o) begin
         if (w_cnt >= 8 || w_last_i != (w_cnt == 7)) begin
            proto_errs++;
         end
         if (w_cnt < 8) begin
            wbuf[w_cnt] = w_data_i;
         end
         w_cnt++;
      end
      // Whole line and its address are in, commit and answer
      if (aw_seen && w_cnt == 8) begin
         for (int k = 0; k < 8; k++) begin
            mem[{last_aw_addr[11:5], 3'(k)}] = wbuf[k];
            last_line[k] = wbuf[k];
         end
         wb_mark[last_aw_addr[11:5]] = 1'b1;
         burst_count++;
         aw_seen = 1'b0;
         w_cnt   = 0;
         b_pend  = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk_o
);

   // 100 ns period
   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
   input  wire                      Clk,
   input  wire                      rst_n_i,
   input  wire                      cpu_req_i,
   input  wire                      cpu_we_i,
   input  wire  dcache_pkg::addr_t  cpu_addr_i,
   input  wire  dcache_pkg::word_t  cpu_wdata_i,
   output wire                      cpu_ready_o,
   output wire  dcache_pkg::word_t  cpu_rdata_o,
   // Read channels
   output wire                      mem_ar_valid_o,
   output wire  dcache_pkg::addr_t  mem_ar_addr_o,
   input  wire                      mem_ar_ready_i,
   input  wire                      mem_r_valid_i,
   input  wire  dcache_pkg::word_t  mem_r_data_i,
   input  wire                      mem_r_last_i,
   // Write channels
   output wire                      mem_aw_valid_o,
   output wire  dcache_pkg::addr_t  mem_aw_addr_o,
   input  wire                      mem_aw_ready_i,
   output wire                      mem_w_valid_o,
   output wire  dcache_pkg::word_t  mem_w_data_o,
   output wire                      mem_w_last_o,
   input  wire                      mem_w_ready_i,
   input  wire                      mem_b_valid_i
);

   logic              lookup;
   logic              word_we;
   logic              fill_we;
   logic              lfb_start;
   logic              lwb_load;
   logic              hit;
   logic              dirty;
   dcache_pkg::word_t arr_rdata;
   dcache_pkg::line_t victim_line;
   dcache_pkg::addr_t victim_addr;
   logic              critical_valid;
   dcache_pkg::word_t critical_word;
   dcache_pkg::line_t fill_line;
   logic              lfb_done;
   logic              lwb_busy;

   dcache_ctrl u_ctrl (
      .Clk              (Clk),
      .rst_n_i          (rst_n_i),
      .cpu_req_i        (cpu_req_i),
      .cpu_we_i         (cpu_we_i),
      .hit_i            (hit),
      .dirty_i          (dirty),
      .rdata_i          (arr_rdata),
      .critical_valid_i (critical_valid),
      .critical_word_i  (critical_word),
      .lfb_done_i       (lfb_done),
      .lwb_busy_i       (lwb_busy),
      .cpu_ready_o      (cpu_ready_o),
      .cpu_rdata_o      (cpu_rdata_o),
      .lookup_o         (lookup),
      .word_we_o        (word_we),
      .fill_we_o        (fill_we),
      .lfb_start_o      (lfb_start),
      .lwb_load_o       (lwb_load)
   );

   dcache_array u_array (
      .Clk           (Clk),
      .rst_n_i       (rst_n_i),
      .addr_i        (cpu_addr_i),
      .lookup_i      (lookup),
      .word_we_i     (word_we),
      .word_i        (cpu_wdata_i),
      .fill_we_i     (fill_we),
      .fill_line_i   (fill_line),
      .hit_o         (hit),
      .dirty_o       (dirty),
      .rdata_o       (arr_rdata),
      .victim_line_o (victim_line),
      .victim_addr_o (victim_addr)
   );

   // Fill and write-back share no state and can overlap
   linefill_buffer u_lfb (
      .Clk              (Clk),
      .rst_n_i          (rst_n_i),
      .start_i          (lfb_start),
      .addr_i           (cpu_addr_i),
      .mem_ar_ready_i   (mem_ar_ready_i),
      .mem_r_valid_i    (mem_r_valid_i),
      .mem_r_data_i     (mem_r_data_i),
      .mem_r_last_i     (mem_r_last_i),
      .mem_ar_valid_o   (mem_ar_valid_o),
      .mem_ar_addr_o    (mem_ar_addr_o),
      .critical_valid_o (critical_valid),
      .critical_word_o  (critical_word),
      .line_o           (fill_line),
      .done_o           (lfb_done)
   );

   line_write_buffer u_lwb (
      .Clk            (Clk),
      .rst_n_i        (rst_n_i),
      .load_i         (lwb_load),
      .line_i         (victim_line),
      .addr_i         (victim_addr),
      .mem_aw_ready_i (mem_aw_ready_i),
      .mem_w_ready_i  (mem_w_ready_i),
      .mem_b_valid_i  (mem_b_valid_i),
      .busy_o         (lwb_busy),
      .mem_aw_valid_o (mem_aw_valid_o),
      .mem_aw_addr_o  (mem_aw_addr_o),
      .mem_w_valid_o  (mem_w_valid_o),
      .mem_w_data_o   (mem_w_data_o),
      .mem_w_last_o   (mem_w_last_o)
   );

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
   input  wire                      Clk,
   input  wire                      rst_n_i,
   input  wire                      cpu_req_i,
   input  wire                      cpu_we_i,
   input  wire                      hit_i,
   input  wire                      dirty_i,
   input  wire  dcache_pkg::word_t  rdata_i,
   input  wire                      critical_valid_i,
   input  wire  dcache_pkg::word_t  critical_word_i,
   input  wire                      lfb_done_i,
   input  wire                      lwb_busy_i,
   output logic                     cpu_ready_o,
   output dcache_pkg::word_t        cpu_rdata_o,
   output logic                     lookup_o,
   output logic                     word_we_o,
   output logic                     fill_we_o,
   output logic                     lfb_start_o,
   output logic                     lwb_load_o
);

   dcache_pkg::ctrl_state_t state_q;
   dcache_pkg::ctrl_state_t state_d;

   logic we_q;
   logic hit_ready_q;
   logic in_lookup;
   logic in_fill;
   logic in_install;
   logic miss_go;

   assign in_lookup  = state_q == dcache_pkg::LOOKUP;
   assign in_fill    = state_q == dcache_pkg::FILL;
   assign in_install = state_q == dcache_pkg::INSTALL;

   ////////////////////
   // Datapath strobes
   ////////////////////

   assign lookup_o = (state_q == dcache_pkg::IDLE) && cpu_req_i;

   // A new miss may not start while an older victim is still draining
   assign miss_go     = in_lookup && !hit_i && !lwb_busy_i;
   assign lfb_start_o = miss_go;
   assign lwb_load_o  = miss_go && dirty_i;

   assign word_we_o = we_q && ((in_lookup && hit_i) || in_install);
   assign fill_we_o = in_install;

   ////////////////////
   // CPU response
   ////////////////////

   // Hits answer from a register, misses answer straight from the fill path
   assign cpu_ready_o = hit_ready_q
                      || (in_fill && !we_q && critical_valid_i)
                      || (in_install && we_q);

   assign cpu_rdata_o = in_fill ? critical_word_i : rdata_i;

   ////////////////////
   // FSM
   ////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         dcache_pkg::IDLE: begin
            if (cpu_req_i) begin
               state_d = dcache_pkg::LOOKUP;
            end
         end
         dcache_pkg::LOOKUP: begin
            if (hit_i) begin
               state_d = dcache_pkg::IDLE;
            end else if (!lwb_busy_i) begin
               state_d = dcache_pkg::FILL;
            end
         end
         dcache_pkg::FILL: begin
            if (lfb_done_i) begin
               state_d = dcache_pkg::INSTALL;
            end
         end
         default: begin
            state_d = dcache_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         state_q     <= dcache_pkg::IDLE;
         hit_ready_q <= 1'b0;
         we_q        <= 1'b0;
      end else begin
         state_q     <= state_d;
         hit_ready_q <= in_lookup && hit_i;
         // Direction is latched, the CPU may move on after a forwarded read
         if (lookup_o) begin
            we_q <= cpu_we_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/line_write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_write_buffer (
   input  wire                      Clk,
   input  wire                      rst_n_i,
   input  wire                      load_i,
   input  wire  dcache_pkg::line_t  line_i,
   input  wire  dcache_pkg::addr_t  addr_i,
   input  wire                      mem_aw_ready_i,
   input  wire                      mem_w_ready_i,
   input  wire                      mem_b_valid_i,
   output logic                     busy_o,
   output logic                     mem_aw_valid_o,
   output dcache_pkg::addr_t        mem_aw_addr_o,
   output logic                     mem_w_valid_o,
   output dcache_pkg::word_t        mem_w_data_o,
   output logic                     mem_w_last_o
);

   dcache_pkg::line_t   line_q;
   dcache_pkg::offset_t beat_q;
   logic                last_beat;

   assign last_beat    = beat_q == dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1);
   assign mem_w_data_o = line_q[{beat_q, 5'b0} +: dcache_pkg::WORD_W];
   assign mem_w_last_o = mem_w_valid_o && last_beat;

   // Address and data channels run on their own handshakes
   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         busy_o         <= 1'b0;
         mem_aw_valid_o <= 1'b0;
         mem_w_valid_o  <= 1'b0;
         beat_q         <= '0;
      end else if (load_i) begin
         busy_o         <= 1'b1;
         mem_aw_valid_o <= 1'b1;
         mem_w_valid_o  <= 1'b1;
         beat_q         <= '0;
      end else begin
         if (mem_aw_valid_o && mem_aw_ready_i) begin
            mem_aw_valid_o <= 1'b0;
         end
         if (mem_w_valid_o && mem_w_ready_i) begin
            if (last_beat) begin
               mem_w_valid_o <= 1'b0;
            end else begin
               beat_q <= beat_q + 1'b1;
            end
         end
         // Held until the memory acknowledges the whole line
         if (busy_o && mem_b_valid_i) begin
            busy_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge Clk) begin
      if (load_i) begin
         line_q        <= line_i;
         mem_aw_addr_o <= addr_i;
      end
   end

endmodule

`default_nettype wire

// File: logic/linefill_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module linefill_buffer (
   input  wire                      Clk,
   input  wire                      rst_n_i,
   input  wire                      start_i,
   input  wire  dcache_pkg::addr_t  addr_i,
   input  wire                      mem_ar_ready_i,
   input  wire                      mem_r_valid_i,
   input  wire  dcache_pkg::word_t  mem_r_data_i,
   input  wire                      mem_r_last_i,
   output logic                     mem_ar_valid_o,
   output dcache_pkg::addr_t        mem_ar_addr_o,
   output logic                     critical_valid_o,
   output dcache_pkg::word_t        critical_word_o,
   output dcache_pkg::line_t        line_o,
   output logic                     done_o
);

   logic                active_q;
   logic                first_q;
   logic                rd_beat;
   dcache_pkg::offset_t beat_off;

   // Read data is never stalled, every valid beat of an open burst counts
   assign rd_beat = active_q && mem_r_valid_i;

   ////////////////////
   // Burst control
   ////////////////////

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         mem_ar_valid_o   <= 1'b0;
         active_q         <= 1'b0;
         first_q          <= 1'b0;
         critical_valid_o <= 1'b0;
         done_o           <= 1'b0;
      end else begin
         critical_valid_o <= 1'b0;
         done_o           <= 1'b0;

         if (start_i) begin
            mem_ar_valid_o <= 1'b1;
            active_q       <= 1'b1;
            first_q        <= 1'b1;
         end else if (mem_ar_valid_o && mem_ar_ready_i) begin
            mem_ar_valid_o <= 1'b0;
         end

         if (rd_beat) begin
            first_q          <= 1'b0;
            critical_valid_o <= first_q;
            if (mem_r_last_i) begin
               active_q <= 1'b0;
               done_o   <= 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Line assembly
   ////////////////////

   // Burst wraps, so the offset counter just rolls over inside the line
   always_ff @(posedge Clk) begin
      if (start_i) begin
         mem_ar_addr_o <= {addr_i[31:2], 2'b00};
         beat_off      <= addr_i[4:2];
      end else if (rd_beat) begin
         line_o[{beat_off, 5'b0} +: dcache_pkg::WORD_W] <= mem_r_data_i;
         beat_off <= beat_off + 1'b1;
         if (first_q) begin
            critical_word_o <= mem_r_data_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
   input  wire                      Clk,
   input  wire                      rst_n_i,
   input  wire  dcache_pkg::addr_t  addr_i,
   input  wire                      lookup_i,
   input  wire                      word_we_i,
   input  wire  dcache_pkg::word_t  word_i,
   input  wire                      fill_we_i,
   input  wire  dcache_pkg::line_t  fill_line_i,
   output logic                     hit_o,
   output logic                     dirty_o,
   output dcache_pkg::word_t        rdata_o,
   output dcache_pkg::line_t        victim_line_o,
   output dcache_pkg::addr_t        victim_addr_o
);

   dcache_pkg::tag_t    tag_in;
   dcache_pkg::index_t  idx_in;
   dcache_pkg::offset_t off_in;
   dcache_pkg::addr_t   addr_q;
   dcache_pkg::tag_t    tag_q;
   dcache_pkg::index_t  idx_q;
   dcache_pkg::offset_t off_q;
   dcache_pkg::line_t   fill_data;

   dcache_pkg::line_t   data_mem [dcache_pkg::NUM_LINES];
   dcache_pkg::tag_t    tag_mem  [dcache_pkg::NUM_LINES];
   logic [dcache_pkg::NUM_LINES-1:0] valid_q;
   logic [dcache_pkg::NUM_LINES-1:0] dirty_q;

   assign tag_in = addr_i[31:8];
   assign idx_in = addr_i[7:5];
   assign off_in = addr_i[4:2];

   // Writes always go to the line of the last lookup
   assign tag_q = addr_q[31:8];
   assign idx_q = addr_q[7:5];
   assign off_q = addr_q[4:2];

   ////////////////////
   // Lookup
   ////////////////////

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         hit_o   <= 1'b0;
         dirty_o <= 1'b0;
      end else if (lookup_i) begin
         hit_o   <= valid_q[idx_in] && (tag_mem[idx_in] == tag_in);
         dirty_o <= valid_q[idx_in] && dirty_q[idx_in];
      end
   end

   always_ff @(posedge Clk) begin
      if (lookup_i) begin
         addr_q        <= addr_i;
         rdata_o       <= data_mem[idx_in][{off_in, 5'b0} +: dcache_pkg::WORD_W];
         victim_line_o <= data_mem[idx_in];
         victim_addr_o <= {tag_mem[idx_in], idx_in, 5'b0};
      end
   end

   ////////////////////
   // Update
   ////////////////////

   // Store word merged into the incoming line on a write miss
   always_comb begin
      fill_data = fill_line_i;
      if (word_we_i) begin
         fill_data[{off_q, 5'b0} +: dcache_pkg::WORD_W] = word_i;
      end
   end

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_we_i) begin
         valid_q[idx_q] <= 1'b1;
         dirty_q[idx_q] <= word_we_i;
      end else if (word_we_i) begin
         dirty_q[idx_q] <= 1'b1;
      end
   end

   always_ff @(posedge Clk) begin
      if (fill_we_i) begin
         data_mem[idx_q] <= fill_data;
         tag_mem[idx_q]  <= tag_q;
      end else if (word_we_i) begin
         data_mem[idx_q][{off_q, 5'b0} +: dcache_pkg::WORD_W] <= word_i;
      end
   end

endmodule

`default_nettype wire

// File: logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   ////////////////////
   // Geometry
   ////////////////////

   localparam int ADDR_W     = 32;
   localparam int WORD_W     = 32;
   localparam int LINE_WORDS = 8;
   localparam int NUM_LINES  = 8;

   // Byte offset inside a word is always 2 bits wide
   localparam int OFFSET_W = 3;
   localparam int INDEX_W  = 3;
   localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - 2;

   ////////////////////
   // Vector types
   ////////////////////

   typedef logic [ADDR_W-1:0]            addr_t;
   typedef logic [WORD_W-1:0]            word_t;
   typedef logic [LINE_WORDS*WORD_W-1:0] line_t;
   typedef logic [TAG_W-1:0]             tag_t;
   typedef logic [INDEX_W-1:0]           index_t;
   typedef logic [OFFSET_W-1:0]          offset_t;

   ////////////////////
   // Controller FSM
   ////////////////////

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      FILL,
      INSTALL
   } ctrl_state_t;

endpackage

`default_nettype wire
